/* bench/decode_model.svh */
// Expected control word per opcode group; MUL decodes only with HS32_ENABLE_MUL, unlisted opcodes trap
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

function automatic control_t predict_control(input logic [31:0] w, output bit traps);
    control_t   c;
    logic [7:0] op;
    bit         alu_grp;  // Register or immediate ALU form
    op              = w[31:24];
    alu_grp         = 1'b0;
    traps           = 1'b0;
    c               = '0;
    c.alu_op        = ALU_ADD;
    c.rd            = w[23:20];
    c.rm            = w[19:16];
    c.rn            = w[15:12];
    c.bank          = w[4:3];
    c.ctl.shift_dir = w[6:5];
    c.ctl.wb        = WB_REG;
    c.ctl.src       = SRC_RM_RN;
    if (op inside {8'h10, 8'h14, 8'h18, 8'h30, 8'h34, 8'h38}) begin
        c.ctl.wb = op[5] ? WB_STORE : WB_LOAD;
        if (op[3]) begin                                  // Shifted register address
            c.ctl.src = op[5] ? SRC_ST_RN : SRC_RM_RN;
            c.shift   = w[11:7];
        end else begin
            c.ctl.src = op[5] ? SRC_ST_IMM : SRC_RM_IMM;
            c.imm     = op[2] ? 16'h0 : w[15:0];         // Plain form has no offset
        end
    end else if (op == 8'h24) begin
        c.alu_op  = ALU_MOV;
        c.ctl.src = SRC_IMM;
        c.imm     = w[15:0];
    end else if (op == 8'h20) begin
        c.alu_op  = ALU_MOV;
        c.ctl.src = SRC_RN;
        c.shift   = w[11:7];
    end else if (op == 8'h2C || op == 8'h2D) begin
        c.alu_op      = ALU_MOV2;
        c.ctl.src     = SRC_RM_IMM;
        c.ctl.bank_rd = 1'b1;
        c.ctl.upd     = op[0] ? 3'b100 : 3'b000;          // Banked write
    end else if (op[7:4] == 4'h4 && op[2:0] <= 3'd5) begin
        case (op[2:1])
            2'd0:    c.alu_op = op[0] ? ALU_ADC : ALU_ADD;
            2'd1:    c.alu_op = ALU_SUB;
            default: c.alu_op = ALU_SBC;
        endcase
        c.ctl.rev = op[0] && (op[2:1] != 2'd0);
        alu_grp   = 1'b1;
    end else if (op == 8'h46 && `HS32_ENABLE_MUL != 0) begin
        c.alu_op = ALU_MUL;
        alu_grp  = 1'b1;
    end else if (op[7:4] == 4'h7 && !op[2]) begin
        case (op[1:0])
            2'd0:    c.alu_op = ALU_AND;
            2'd1:    c.alu_op = ALU_BIC;
            2'd2:    c.alu_op = ALU_OR;
            default: c.alu_op = ALU_XOR;
        endcase
        alu_grp = 1'b1;
    end else if (op inside {8'h80, 8'h81, 8'h88, 8'h89}) begin
        c.alu_op = op[0] ? ALU_AND : ALU_SUB;
        c.ctl.wb = WB_NONE;                               // Flags only
        alu_grp  = 1'b1;
    end else if (op[7:4] == 4'h5) begin
        c.ctl.wb   = WB_NONE;
        c.ctl.src  = SRC_NONE;
        c.ctl.cond = op[3:0];
        c.ctl.upd  = 3'b001;
        c.imm      = w[15:0];
    end else if (op[7:4] == 4'h6) begin
        c.alu_op   = ALU_MOV;
        c.ctl.rev  = 1'b1;
        c.ctl.src  = SRC_RM_IMM;
        c.ctl.cond = op[3:0];
        c.ctl.upd  = 3'b001;
        c.imm      = w[15:0];
        c.rd       = 4'd14;                               // Link register
        c.rm       = 4'hF;
        c.rn       = 4'hF;
    end else begin
        traps = 1'b1;                                     // SWI and undefined
    end
    if (alu_grp) begin
        c.ctl.upd = 3'b010;
        if (op[3]) begin
            c.ctl.src = SRC_RM_IMM;
            c.imm     = w[15:0];
        end else begin
            c.ctl.src = SRC_RM_RN;
            c.shift   = w[11:7];
        end
    end
    return c;
endfunction

`endif

/* bench/tb_hs32_decode.sv */
// Needs a simulator with timing support and stops at the first failing check
`timescale 1ns/10ps
`default_nettype none

`include "hs32_config.svh"

module tb_hs32_decode import hs32_pkg::*; ();

    `include "decode_model.svh"

    localparam int clk_half   = 10;
    localparam int wait_limit = 200;  // Cycles before any wait gives up

    // Opcodes that decode without a trap
    localparam logic [7:0] legal_ops [36] = '{
        8'h10, 8'h14, 8'h18, 8'h20, 8'h24, 8'h2C, 8'h2D, 8'h30, 8'h34, 8'h38,
        8'h40, 8'h41, 8'h42, 8'h43, 8'h44, 8'h45, 8'h48, 8'h49, 8'h4A, 8'h4B,
        8'h4C, 8'h4D, 8'h70, 8'h71, 8'h72, 8'h73, 8'h78, 8'h79, 8'h7A, 8'h7B,
        8'h80, 8'h81, 8'h88, 8'h89, 8'h50, 8'h60
    };

    logic                       clk;
    logic                       reset;
    logic [`HS32_INSN_W-1:0]    insn;
    logic                       insn_valid;
    logic                       insn_ready;
    control_t                   control;
    logic                       control_valid;
    logic                       control_ready;
    logic [`HS32_INT_LINES-1:0] int_line;

    int                         ready_mode;     // 0 ready, 1 random stalls, 2 held off
    control_t                   exp_q[$];
    int unsigned                in_count;
    int unsigned                out_count;
    int unsigned                pulse_count;
    int unsigned                outs_at_pulse;  // Output transfers seen before the pulse
    logic [`HS32_INT_LINES-1:0] last_line;

    hs32_decode i_dut (
        .clk           (clk),
        .reset         (reset),
        .insn          (insn),
        .insn_valid    (insn_valid),
        .insn_ready    (insn_ready),
        .control       (control),
        .control_valid (control_valid),
        .control_ready (control_ready),
        .int_line      (int_line)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    always @(posedge clk) begin
        case (ready_mode)
            0:       control_ready <= 1'b1;
            1:       control_ready <= ($urandom % 3) != 0;
            default: control_ready <= 1'b0;
        endcase
    end

    // Scoreboard for fetch and execute transfers
    always @(posedge clk) begin
        control_t exp_word;
        bit       exp_trap;
        if (!reset) begin
            if (control_valid && control_ready) begin
                assert (exp_q.size() > 0)
                    else report_failure("output transfer with no instruction pending");
                assert (control == exp_q[0])
                    else report_mismatch("control", $sformatf("%h", exp_q[0]),
                                         $sformatf("%h", control));
                void'(exp_q.pop_front());
                out_count <= out_count + 1;
            end
            if (insn_valid && insn_ready) begin
                exp_word = predict_control(insn, exp_trap);
                if (!exp_trap) begin
                    exp_q.push_back(exp_word);
                    in_count <= in_count + 1;
                end
            end
            if (int_line != '0) begin
                pulse_count   <= pulse_count + 1;
                last_line     <= int_line;
                outs_at_pulse <= out_count;
            end
        end
    end

    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        control_valid && !control_ready |=> control_valid && $stable(control))
        else report_failure("control changed while execute stalled");

    a_stall_closed: assert property (@(posedge clk) disable iff (reset)
        control_valid && !control_ready |-> !insn_ready)
        else report_failure("insn_ready high while the output is stalled");

    a_pulse_width: assert property (@(posedge clk) disable iff (reset)
        int_line != '0 |=> int_line == '0)
        else report_failure("int_line pulse longer than one cycle");

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input string exp_s, input string got_s);
        $display("MISMATCH at %0t: %s expected %s got %s", $time, name, exp_s, got_s);
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] random_insn();
        logic [5:0] idx;
        logic [7:0] op;
        idx = 6'($urandom_range(35, 0));
        op  = legal_ops[idx];
        if (op[7:4] == 4'h5 || op[7:4] == 4'h6) begin
            op[3:0] = 4'($urandom);  // Condition code
        end
        return {op, 24'($urandom)};
    endfunction

    // Starts and ends just after a rising edge
    task automatic apply_reset();
        reset      <= 1'b1;
        insn_valid <= 1'b0;
        ready_mode <= 0;
        repeat (16) @(posedge clk);
        exp_q.delete();
        in_count      <= 0;
        out_count     <= 0;
        pulse_count   <= 0;
        outs_at_pulse <= 0;
        last_line     <= '0;
        reset         <= 1'b0;
        @(posedge clk);
        assert (!control_valid && !insn_ready && int_line == '0)
            else report_failure("outputs not idle right after reset");
        @(posedge clk);
        assert (insn_ready) else report_failure("insn_ready did not rise after reset");
    endtask

    task automatic send_insn(input logic [31:0] w);
        int n;
        insn       <= w;
        insn_valid <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            assert (n <= wait_limit) else report_failure("fetch transfer timed out");
        end while (!insn_ready);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (out_count != in_count || control_valid) begin
            @(posedge clk);
            n++;
            assert (n <= wait_limit) else report_failure("decoded words did not drain");
        end
    endtask

    task automatic wait_pulse();
        int n;
        n = 0;
        while (pulse_count == 0) begin
            @(posedge clk);
            n++;
            assert (n <= wait_limit) else report_failure("no interrupt pulse after a trap");
        end
    endtask

    task automatic offer_while_halted(input logic [31:0] w, input int cycles);
        insn       <= w;
        insn_valid <= 1'b1;
        repeat (cycles) begin
            @(posedge clk);
            assert (!insn_ready) else report_failure("insn_ready high after a trap");
        end
        insn_valid <= 1'b0;
    endtask

    task automatic check_trap(input logic [31:0] w, input bit pulses, input int line);
        logic [`HS32_INT_LINES-1:0] exp_line;
        exp_line    = '0;
        exp_line[0] = 1'b1;
        exp_line    = exp_line << line;
        apply_reset();
        send_insn(w);
        insn_valid <= 1'b0;
        if (pulses) begin
            wait_pulse();
            assert (last_line == exp_line)
                else report_mismatch("int_line", $sformatf("%h", exp_line),
                                     $sformatf("%h", last_line));
        end
        offer_while_halted(random_insn(), 20);
        assert (pulse_count == (pulses ? 1 : 0))
            else report_mismatch("pulse_count", $sformatf("%0d", pulses ? 1 : 0),
                                 $sformatf("%0d", pulse_count));
    endtask

    // SWI offered while a word sits stalled in the slot
    task automatic stalled_trap();
        logic [31:0] swi;
        swi = {8'hF0, 8'($urandom), 16'd7};
        apply_reset();
        ready_mode <= 2;
        send_insn(random_insn());
        insn <= swi;
        repeat (10) begin
            @(posedge clk);
            assert (!insn_ready && int_line == '0)
                else report_failure("trap accepted or pulsed while the slot was stalled");
        end
        ready_mode <= 0;
        send_insn(swi);
        insn_valid <= 1'b0;
        wait_pulse();
        assert (outs_at_pulse == 1)
            else report_mismatch("outs_at_pulse", "1", $sformatf("%0d", outs_at_pulse));
        assert (last_line == 24'h80)
            else report_mismatch("int_line", "000080", $sformatf("%h", last_line));
    endtask

    initial begin
        void'($urandom(32'h9f4));
        reset         = 1'b1;
        insn          = '0;
        insn_valid    = 1'b0;
        control_ready = 1'b1;
        ready_mode    = 0;
        in_count      = 0;
        out_count     = 0;
        pulse_count   = 0;
        outs_at_pulse = 0;
        last_line     = '0;
        @(posedge clk);

        apply_reset();                          // All groups at full rate
        repeat (200) send_insn(random_insn());
        insn_valid <= 1'b0;
        wait_drain();

        ready_mode <= 1;                        // Random stalls and fetch gaps
        repeat (300) begin
            if (($urandom % 4) == 0) begin
                insn_valid <= 1'b0;
                @(posedge clk);
            end
            send_insn(random_insn());
        end
        insn_valid <= 1'b0;
        ready_mode <= 0;
        wait_drain();

        check_trap({8'hF0, 8'($urandom), 16'd5}, 1'b1, 5);
        check_trap({8'hF0, 8'($urandom), 16'd0}, 1'b1, 0);
        check_trap({8'hF0, 8'($urandom), 16'd30}, 1'b0, 0);   // Beyond the last line
        check_trap({8'h47, 24'($urandom)}, 1'b1, 0);
        check_trap({8'hA5, 24'($urandom)}, 1'b1, 0);
        if (`HS32_ENABLE_MUL == 0) begin
            check_trap({8'h46, 24'($urandom)}, 1'b1, 0);
        end
        stalled_trap();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* hs32_decode.f */
+incdir+verilog
+incdir+bench
verilog/hs32_pkg.sv
verilog/decoded_if.sv
verilog/opcode_table.sv
verilog/decode_pipe.sv
verilog/trap_ctrl.sv
verilog/hs32_decode.sv
bench/tb_hs32_decode.sv

/* run_sim.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_hs32_decode \
    -f hs32_decode.f -o tb_hs32_decode || { echo "Build failed"; exit 1; }
./obj_dir/tb_hs32_decode > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

/* verilog/decode_pipe.sv */
// One-entry output slot; a trap is accepted but never loads the slot
`timescale 1ns/10ps
`default_nettype none

module decode_pipe import hs32_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     insn_valid,
    output logic     insn_ready,
    decoded_if.pipe  dec,
    input  logic     halt,
    output logic     pipe_empty,
    output control_t control,
    output logic     control_valid,
    input  logic     control_ready
);

    logic full;  // Slot holds a word for execute
    logic load;  // Accepted instruction that is not a trap

    // Slot frees up in the same edge it is taken by execute
    assign insn_ready = !halt && (!full || control_ready);
    assign load       = insn_valid && insn_ready && (dec.trap == TRAP_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (control_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            control <= dec.word;
        end
    end

    assign control_valid = full;
    assign pipe_empty    = !full;

    // Stalled word must survive until execute takes it
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        control_valid && !control_ready |=> control_valid && $stable(control))
        else $error("control changed while stalled");

    // A trap halt holds until reset and keeps fetch closed
    a_halt_closed: assert property (@(posedge clk) disable iff (reset)
        halt && !$past(reset) |=> halt && !insn_ready)
        else $error("halt dropped or insn_ready high after a trap");

endmodule

`default_nettype wire

/* verilog/decoded_if.sv */
// Combinational result of one decode; valid only while the instruction input is stable
`timescale 1ns/10ps
`default_nettype none

`include "hs32_config.svh"

interface decoded_if import hs32_pkg::*; ();

    control_t               word;    // Control word for execute
    trap_e                  trap;    // Trap kind, NONE for normal ops
    logic [`HS32_IMM_W-1:0] vector;  // SWI number

    modport tbl (
        output word,
        output trap,
        output vector
    );

    modport pipe (
        input word,
        input trap,
        input vector
    );

endinterface

`default_nettype wire

/* verilog/hs32_config.svh */
// Build-time options only; widths must agree with the field layout in hs32_pkg

`ifndef HS32_CONFIG_SVH
`define HS32_CONFIG_SVH

// Instruction word as delivered by fetch
`define HS32_INSN_W 32

// Immediate field, also the SWI vector
`define HS32_IMM_W 16

// Register index, 16 registers
`define HS32_REG_W 4

// Barrel shift amount
`define HS32_SHIFT_W 5

// Interrupt lines, higher SWI vectors raise nothing
`define HS32_INT_LINES 24

// 1 decodes MUL, 0 makes it trap as undefined
`define HS32_ENABLE_MUL 0

`endif

/* verilog/hs32_decode.sv */
// Decode stage top; one cycle latency, halts for good on any trap until reset
`timescale 1ns/10ps
`default_nettype none

`include "hs32_config.svh"

module hs32_decode import hs32_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`HS32_INSN_W-1:0]    insn,
    input  logic                       insn_valid,
    output logic                       insn_ready,
    output control_t                   control,
    output logic                       control_valid,
    input  logic                       control_ready,
    output logic [`HS32_INT_LINES-1:0] int_line
);

    logic halt;
    logic pipe_empty;
    logic accept;  // Fetch transfer this edge

    decoded_if dec ();

    assign accept = insn_valid && insn_ready;

    opcode_table i_table (
        .insn (insn_t'(insn)),
        .dec  (dec.tbl)
    );

    decode_pipe i_pipe (
        .clk           (clk),
        .reset         (reset),
        .insn_valid    (insn_valid),
        .insn_ready    (insn_ready),
        .dec           (dec.pipe),
        .halt          (halt),
        .pipe_empty    (pipe_empty),
        .control       (control),
        .control_valid (control_valid),
        .control_ready (control_ready)
    );

    trap_ctrl i_trap (
        .clk        (clk),
        .reset      (reset),
        .accept     (accept),
        .dec        (dec.pipe),
        .pipe_empty (pipe_empty),
        .halt       (halt),
        .int_line   (int_line)
    );

endmodule

`default_nettype wire

/* verilog/hs32_pkg.sv */
// Opcode byte values are this core's own encoding; branch forms use the low nibble as condition
`default_nettype none

`include "hs32_config.svh"

package hs32_pkg;

    typedef enum logic [7:0] {
        OP_LDRI   = 8'h10,    // Rd <- [Rm + imm]
        OP_LDR    = 8'h14,    // Rd <- [Rm]
        OP_LDRA   = 8'h18,    // Rd <- [Rm + sh(Rn)]
        OP_MOVN   = 8'h20,    // Rd <- sh(Rn)
        OP_MOVI   = 8'h24,    // Rd <- imm
        OP_MOV    = 8'h2C,    // Rd <- Rm_b
        OP_MOVR   = 8'h2D,    // Rd_b <- Rm
        OP_STRI   = 8'h30,
        OP_STR    = 8'h34,
        OP_STRA   = 8'h38,
        OP_ADD    = 8'h40,    // Register ALU forms, low bits pick the operation
        OP_ADDC   = 8'h41,
        OP_SUB    = 8'h42,
        OP_RSUB   = 8'h43,
        OP_SUBC   = 8'h44,
        OP_RSUBC  = 8'h45,
        OP_MUL    = 8'h46,
        OP_ADDI   = 8'h48,    // Bit 3 set marks the immediate form
        OP_ADDIC  = 8'h49,
        OP_SUBI   = 8'h4A,
        OP_RSUBI  = 8'h4B,
        OP_SUBIC  = 8'h4C,
        OP_RSUBIC = 8'h4D,
        OP_B      = 8'h50,    // 5c, c is the condition
        OP_BL     = 8'h60,    // 6c, link into R14
        OP_AND    = 8'h70,
        OP_BIC    = 8'h71,
        OP_OR     = 8'h72,
        OP_XOR    = 8'h73,
        OP_ANDI   = 8'h78,
        OP_BICI   = 8'h79,
        OP_ORI    = 8'h7A,
        OP_XORI   = 8'h7B,
        OP_CMP    = 8'h80,
        OP_TST    = 8'h81,
        OP_CMPI   = 8'h88,
        OP_TSTI   = 8'h89,
        OP_INT    = 8'hF0     // Software interrupt, vector in imm
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_MOV, ALU_MOV2, ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_MUL, ALU_AND, ALU_BIC, ALU_OR, ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {WB_NONE, WB_REG, WB_LOAD, WB_STORE} wb_e;

    // Operand routing for execute
    typedef enum logic [2:0] {
        SRC_NONE, SRC_IMM, SRC_RM_IMM, SRC_RM_RN, SRC_RN, SRC_ST_IMM, SRC_ST_RN
    } src_e;

    typedef enum logic [1:0] {TRAP_NONE, TRAP_SWI, TRAP_UNDEF} trap_e;

    // Register-operand view of the low half
    typedef struct packed {
        logic [`HS32_REG_W-1:0]   rn;
        logic [`HS32_SHIFT_W-1:0] shift;
        logic [1:0]               dir;
        logic [1:0]               bank;
        logic [2:0]               rsvd;
    } insn_reg_t;

    typedef union packed {
        logic [`HS32_IMM_W-1:0] imm;
        insn_reg_t              f;
    } insn_lo_u;

    typedef struct packed {
        opcode_e                opcode;
        logic [`HS32_REG_W-1:0] rd;
        logic [`HS32_REG_W-1:0] rm;
        insn_lo_u               lo;
    } insn_t;

    typedef struct packed {
        wb_e        wb;
        logic       rev;          // Swap ALU operands
        src_e       src;
        logic [3:0] cond;
        logic [2:0] upd;          // Bank write, flag update, branch
        logic [1:0] shift_dir;
        logic       bank_rd;
    } ctl_t;

    typedef struct packed {
        alu_op_e                  alu_op;
        logic [`HS32_SHIFT_W-1:0] shift;
        logic [`HS32_IMM_W-1:0]   imm;
        logic [`HS32_REG_W-1:0]   rd;
        logic [`HS32_REG_W-1:0]   rm;
        logic [`HS32_REG_W-1:0]   rn;
        logic [1:0]               bank;
        ctl_t                     ctl;
    } control_t;

endpackage

`default_nettype wire

/* verilog/opcode_table.sv */
// Pure combinational decode; MUL traps unless HS32_ENABLE_MUL is 1
`timescale 1ns/10ps
`default_nettype none

`include "hs32_config.svh"

module opcode_table import hs32_pkg::*; (
    input  insn_t  insn,
    decoded_if.tbl dec
);

    alu_op_e                alu;
    wb_e                    wb;
    src_e                   src;
    trap_e                  trap;
    logic                   rev;
    logic [2:0]             upd;
    logic [3:0]             cond;
    logic                   bank_rd;
    logic                   imm_form;  // Pass immediate, zero shift
    logic                   sh_form;   // Pass shift, zero immediate
    logic                   alu_form;  // Register or immediate ALU group
    logic [`HS32_REG_W-1:0] rd_sel;
    logic [`HS32_REG_W-1:0] rm_sel;
    logic [`HS32_REG_W-1:0] rn_sel;

    function automatic alu_op_e arith_op(input logic [2:0] sel);
        case (sel)
            3'd0:       return ALU_ADD;
            3'd1:       return ALU_ADC;
            3'd2, 3'd3: return ALU_SUB;  // Odd codes are the reverse forms
            3'd4, 3'd5: return ALU_SBC;
            default:    return ALU_MUL;
        endcase
    endfunction

    always_comb begin
        alu      = ALU_ADD;
        wb       = WB_REG;
        src      = SRC_RM_RN;
        trap     = TRAP_NONE;
        rev      = 1'b0;
        upd      = 3'b000;
        cond     = 4'h0;
        bank_rd  = 1'b0;
        imm_form = 1'b0;
        sh_form  = 1'b0;
        alu_form = 1'b0;
        rd_sel   = insn.rd;
        rm_sel   = insn.rm;
        rn_sel   = insn.lo.f.rn;

        case (insn.opcode) inside
            OP_LDRI, OP_LDR, OP_LDRA: begin
                wb       = WB_LOAD;
                src      = (insn.opcode == OP_LDRA) ? SRC_RM_RN : SRC_RM_IMM;
                imm_form = (insn.opcode == OP_LDRI);
                sh_form  = (insn.opcode == OP_LDRA);
            end
            OP_STRI, OP_STR, OP_STRA: begin
                wb       = WB_STORE;
                src      = (insn.opcode == OP_STRA) ? SRC_ST_RN : SRC_ST_IMM;
                imm_form = (insn.opcode == OP_STRI);
                sh_form  = (insn.opcode == OP_STRA);
            end
            OP_MOVI: begin
                alu      = ALU_MOV;
                src      = SRC_IMM;
                imm_form = 1'b1;
            end
            OP_MOVN: begin
                alu     = ALU_MOV;
                src     = SRC_RN;
                sh_form = 1'b1;
            end
            OP_MOV, OP_MOVR: begin
                alu     = ALU_MOV2;
                src     = SRC_RM_IMM;                             // Imm stays zero
                bank_rd = 1'b1;
                upd     = (insn.opcode == OP_MOVR) ? 3'b100 : 3'b000;  // Write to bank
            end
            [OP_ADD:OP_RSUBC], [OP_ADDI:OP_RSUBIC]: begin
                alu      = arith_op(insn.opcode[2:0]);
                rev      = (insn.opcode[2:0] == 3'd3) || (insn.opcode[2:0] == 3'd5);
                alu_form = 1'b1;
            end
            OP_MUL: begin
                alu      = ALU_MUL;
                alu_form = 1'b1;
                if (`HS32_ENABLE_MUL == 0) begin
                    trap = TRAP_UNDEF;
                end
            end
            [OP_AND:OP_XOR], [OP_ANDI:OP_XORI]: begin
                alu      = alu_op_e'(ALU_AND + insn.opcode[1:0]);  // AND BIC OR XOR in order
                alu_form = 1'b1;
            end
            OP_CMP, OP_TST, OP_CMPI, OP_TSTI: begin
                alu      = insn.opcode[0] ? ALU_AND : ALU_SUB;
                wb       = WB_NONE;                                  // Flags only
                alu_form = 1'b1;
            end
            8'h5?: begin                                             // B<c>
                wb       = WB_NONE;
                src      = SRC_NONE;
                cond     = insn.opcode[3:0];
                upd      = 3'b001;
                imm_form = 1'b1;
            end
            8'h6?: begin                                             // B<c>L
                alu      = ALU_MOV;
                rev      = 1'b1;
                src      = SRC_RM_IMM;
                cond     = insn.opcode[3:0];
                upd      = 3'b001;
                imm_form = 1'b1;
                rd_sel   = 4'd14;                                    // Link register
                rm_sel   = '1;                                       // PC
                rn_sel   = '1;
            end
            OP_INT: begin
                trap = TRAP_SWI;
            end
            default: begin
                trap = TRAP_UNDEF;
            end
        endcase

        // Shared setup for all ALU forms, bit 3 picks the immediate variant
        if (alu_form) begin
            upd      = 3'b010;
            imm_form = insn.opcode[3];
            sh_form  = !insn.opcode[3];
            src      = insn.opcode[3] ? SRC_RM_IMM : SRC_RM_RN;
        end
    end

    assign dec.word = '{
        alu_op: alu,
        shift:  sh_form ? insn.lo.f.shift : '0,
        imm:    imm_form ? insn.lo.imm : '0,
        rd:     rd_sel,
        rm:     rm_sel,
        rn:     rn_sel,
        bank:   insn.lo.f.bank,
        ctl:    '{wb: wb, rev: rev, src: src, cond: cond, upd: upd,
                  shift_dir: insn.lo.f.dir, bank_rd: bank_rd}
    };
    assign dec.trap   = trap;
    assign dec.vector = insn.lo.imm;

endmodule

`default_nettype wire

/* verilog/trap_ctrl.sv */
// Halt holds until reset; SWI vectors of HS32_INT_LINES and above halt without a pulse
`timescale 1ns/10ps
`default_nettype none

`include "hs32_config.svh"

module trap_ctrl import hs32_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       accept,
    decoded_if.pipe                    dec,
    input  logic                       pipe_empty,
    output logic                       halt,
    output logic [`HS32_INT_LINES-1:0] int_line
);

    localparam int line_w = $clog2(`HS32_INT_LINES);

    logic                       take;      // Trap instruction accepted this edge
    logic                       trapped;   // Sticky until reset
    logic                       pend;      // Pulse still owed
    trap_e                      kind_q;
    logic [`HS32_IMM_W-1:0]     vector_q;
    logic [`HS32_INT_LINES-1:0] line_sel;

    assign take = accept && (dec.trap != TRAP_NONE);

    // Halt also covers reset so fetch stays closed until the first clean cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            halt    <= 1'b1;
            trapped <= 1'b0;
            pend    <= 1'b0;
        end else begin
            halt    <= trapped || take;
            trapped <= trapped || take;
            if (take) begin
                pend <= 1'b1;
            end else if (pend && pipe_empty) begin
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            kind_q   <= dec.trap;
            vector_q <= dec.vector;
        end
    end

    always_comb begin
        line_sel = '0;
        if (kind_q == TRAP_UNDEF) begin
            line_sel[0] = 1'b1;                          // Undefined shares line 0
        end else if (vector_q < `HS32_INT_LINES) begin
            line_sel[vector_q[line_w-1:0]] = 1'b1;
        end
    end

    // Waits for the pending word to leave, then fires once
    assign int_line = (pend && pipe_empty) ? line_sel : '0;

    a_one_pulse: assert property (@(posedge clk) disable iff (reset)
        (int_line != '0) |-> $onehot(int_line) ##1 (int_line == '0))
        else $error("int_line not a single one-cycle pulse");

endmodule

`default_nettype wire
